// ==== Bender.yml ====
package:
  name: exec_slice

export_include_dirs:
  - verilog

sources:
  - verilog/core_pkg.sv
  - verilog/dec_decode.sv
  - verilog/reg_file.sv
  - verilog/alu.sv
  - verilog/exec_slice.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_exec_slice.sv

// ==== tb.f ====
+incdir+verilog
+incdir+verif
verilog/core_pkg.sv
verilog/dec_decode.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/exec_slice.sv
verif/tb_exec_slice.sv

// ==== verif/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

localparam logic [1:0] K_RES   = 2'd0;
localparam logic [1:0] K_LOAD  = 2'd1;
localparam logic [1:0] K_STORE = 2'd2;
localparam logic [1:0] K_TRAP  = 2'd3;

// One expected output pulse, data holds the result, address or trap pc
typedef struct packed {
  logic [1:0]  kind;
  logic [4:0]  rd;
  logic [31:0] data;
  logic [3:0]  op;
  logic [31:0] wdata;
  logic [31:0] cyc;
} exp_t;

logic [31:0] model_regs [32];

function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
  case (f3)
    3'b000: return alt ? a - b : a + b;
    3'b001: return a << b[4:0];
    3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'b011: return (a < b) ? 32'd1 : 32'd0;
    3'b100: return a ^ b;
    3'b101: begin
      if (alt) begin
        return $signed(a) >>> b[4:0];
      end
      return a >> b[4:0];
    end
    3'b110: return a | b;
    default: return a & b;
  endcase
endfunction

// Compressed forms: CI, CB and CA layouts, upper half left zero
task automatic pick_compressed(input logic [31:0] r, output logic [31:0] word, inout exp_t e);
  logic [4:0]  rd;
  logic [4:0]  rs2;
  logic [4:0]  rdp;
  logic [4:0]  rs2p;
  logic [5:0]  imm6;
  logic [31:0] cimm;
  rd   = r[4:0];
  rs2  = (r[14:10] == 5'd0) ? 5'd1 : r[14:10];
  rdp  = {2'b01, r[7:5]};
  rs2p = {2'b01, r[12:10]};
  imm6 = r[24:19];
  cimm = {{26{imm6[5]}}, imm6};
  e.rd = rd;
  case ($urandom_range(0, 6))
    0: begin
      word   = {16'h0, 3'b000, imm6[5], rd, imm6[4:0], 2'b01};
      e.data = model_regs[rd] + cimm;
    end
    1: begin
      word   = {16'h0, 3'b010, imm6[5], rd, imm6[4:0], 2'b01};
      e.data = cimm;
    end
    2: begin
      // x2 selects C.ADDI16SP
      e.rd   = (rd == 5'd2) ? 5'd3 : rd;
      word   = {16'h0, 3'b011, imm6[5], e.rd, imm6[4:0], 2'b01};
      e.data = cimm << 12;
    end
    3: begin
      e.rd   = rdp;
      word   = {16'h0, 3'b100, imm6[5], 2'b10, rdp[2:0], imm6[4:0], 2'b01};
      e.data = model_regs[rdp] & cimm;
    end
    4: begin
      e.rd = rdp;
      word = {16'h0, 6'b100011, rdp[2:0], r[26:25], rs2p[2:0], 2'b01};
      case (r[26:25])
        2'b00: e.data = model_regs[rdp] - model_regs[rs2p];
        2'b01: e.data = model_regs[rdp] ^ model_regs[rs2p];
        2'b10: e.data = model_regs[rdp] | model_regs[rs2p];
        default: e.data = model_regs[rdp] & model_regs[rs2p];
      endcase
    end
    5: begin
      word   = {16'h0, 4'b1000, rd, rs2, 2'b10};
      e.data = model_regs[rs2];
    end
    default: begin
      word   = {16'h0, 4'b1001, rd, rs2, 2'b10};
      e.data = model_regs[rd] + model_regs[rs2];
    end
  endcase
endtask

// Draws one instruction, builds its expected pulse and updates the model registers
task automatic pick_instr(input logic [31:0] pc, output logic [31:0] word, output exp_t e);
  logic [31:0] r;
  logic [31:0] r2;
  logic [4:0]  rd;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [2:0]  f3;
  logic        alt;
  logic [11:0] imm12;
  logic [31:0] a;
  logic [31:0] b;
  int          kind;
  int          sel;
  r     = $urandom;
  r2    = $urandom;
  rd    = r[4:0];
  rs1   = r[9:5];
  rs2   = r[14:10];
  f3    = r[17:15];
  alt   = r[18];
  imm12 = r2[11:0];
  a     = model_regs[rs1];
  b     = model_regs[rs2];
  e     = '0;
  e.kind = K_RES;
  e.rd   = rd;
  kind   = $urandom_range(0, 99);
  if (kind < 25) begin
    alt    = alt && (f3 == 3'b000 || f3 == 3'b101);
    word   = {alt ? 7'b0100000 : 7'b0000000, rs2, rs1, f3, rd, 7'b0110011};
    e.data = alu_ref(f3, alt, a, b);
  end else if (kind < 45) begin
    alt = alt && (f3 == 3'b101);
    if (f3 == 3'b001 || f3 == 3'b101) begin
      imm12 = {1'b0, alt, 5'b0, imm12[4:0]};
    end
    word   = {imm12, rs1, f3, rd, 7'b0010011};
    e.data = alu_ref(f3, alt, a, {{20{imm12[11]}}, imm12});
  end else if (kind < 50) begin
    word   = {r2[31:12], rd, 7'b0110111};
    e.data = {r2[31:12], 12'b0};
  end else if (kind < 55) begin
    word   = {r2[31:12], rd, 7'b0010111};
    e.data = pc + {r2[31:12], 12'b0};
  end else if (kind < 72) begin
    e.rd   = '0;
    e.data = a + {{20{imm12[11]}}, imm12};
    if (kind < 64) begin
      sel    = $urandom_range(0, 4);
      e.kind = K_LOAD;
      case (sel)
        0: begin f3 = 3'b000; e.op = LSU_LB; end
        1: begin f3 = 3'b001; e.op = LSU_LH; end
        2: begin f3 = 3'b010; e.op = LSU_LW; end
        3: begin f3 = 3'b100; e.op = LSU_LBU; end
        default: begin f3 = 3'b101; e.op = LSU_LHU; end
      endcase
      word = {imm12, rs1, f3, rd, 7'b0000011};
    end else begin
      sel     = $urandom_range(0, 2);
      e.kind  = K_STORE;
      e.wdata = b;
      case (sel)
        0: begin f3 = 3'b000; e.op = LSU_SB; end
        1: begin f3 = 3'b001; e.op = LSU_SH; end
        default: begin f3 = 3'b010; e.op = LSU_SW; end
      endcase
      word = {imm12[11:5], rs2, rs1, f3, imm12[4:0], 7'b0100011};
    end
  end else if (kind < 96) begin
    pick_compressed(r, word, e);
  end else begin
    // Jumps, branches, system, M extension and the all-zero word
    e.kind = K_TRAP;
    e.rd   = '0;
    e.data = pc;
    case ($urandom_range(0, 5))
      0: word = {r2[31:7], 7'b1101111};
      1: word = {r2[31:7], 7'b1100111};
      2: word = {r2[31:7], 7'b1100011};
      3: word = {r2[31:7], 7'b1110011};
      4: word = {7'b0000001, rs2, rs1, f3, rd, 7'b0110011};
      default: word = 32'h0;
    endcase
  end
  if (e.kind == K_RES && e.rd != 5'd0) begin
    model_regs[e.rd] = e.data;
  end
endtask

`endif

// ==== verif/tb_exec_slice.sv ====
`timescale 1ns/1ps

module tb_exec_slice
  import core_pkg::*;
();

  localparam int NUM_RANDOM  = 2000;
  localparam int END_TIMEOUT = 50;

  logic        clk;
  logic        arst_n;
  logic        instr_valid;
  logic [31:0] instr;
  logic [31:0] pc;
  logic        res_valid;
  logic [4:0]  res_rd;
  logic [31:0] res_data;
  logic        mem_rd_en;
  logic        mem_wr_en;
  lsu_op_t     mem_op;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic        trap;
  logic [31:0] trap_pc;
  int unsigned cycle = 0;

  `include "tb_model.svh"

  exp_t exp_q[$];

  exec_slice i_exec_slice (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .pc          (pc),
    .res_valid   (res_valid),
    .res_rd      (res_rd),
    .res_data    (res_data),
    .mem_rd_en   (mem_rd_en),
    .mem_wr_en   (mem_wr_en),
    .mem_op      (mem_op),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .trap        (trap),
    .trap_pc     (trap_pc)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1, "stopped at first error");
  endtask

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
    if (got !== exp) begin
      report_error($sformatf("[FAIL] %s exp 0x%h got 0x%h", name, exp, got));
    end
  endtask

  task automatic drive_instr(input logic [31:0] word, input logic [31:0] addr, input exp_t e);
    exp_t rec;
    rec     = e;
    rec.cyc = cycle;
    exp_q.push_back(rec);
    instr_valid = 1'b1;
    instr       = word;
    pc          = addr;
  endtask

  // Outputs settle after the rising edge, so they are sampled on the falling edge
  always @(negedge clk) begin : monitor
    exp_t e;
    if ((res_valid | mem_rd_en | mem_wr_en | trap) !== 1'b0) begin
      if (exp_q.size() == 0) begin
        report_error("Output pulse seen with no instruction outstanding");
      end else begin
        e = exp_q.pop_front();
        compare_value("latency", 32'd1, cycle - e.cyc);
        compare_value("res_valid", e.kind == K_RES, res_valid);
        compare_value("mem_rd_en", e.kind == K_LOAD, mem_rd_en);
        compare_value("mem_wr_en", e.kind == K_STORE, mem_wr_en);
        compare_value("trap", e.kind == K_TRAP, trap);
        case (e.kind)
          K_RES: begin
            compare_value("res_rd", e.rd, res_rd);
            compare_value("res_data", e.data, res_data);
          end
          K_LOAD, K_STORE: begin
            compare_value("mem_op", e.op, mem_op);
            compare_value("mem_addr", e.data, mem_addr);
            if (e.kind == K_STORE) begin
              compare_value("mem_wdata", e.wdata, mem_wdata);
            end
          end
          default: compare_value("trap_pc", e.data, trap_pc);
        endcase
      end
    end
  end

  initial begin
    logic [31:0] word;
    logic [31:0] next_pc;
    logic [31:0] seed;
    logic [4:0]  r5;
    exp_t        e;
    int          n;
    seed        = $urandom(74952);
    arst_n      = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    pc          = '0;
    for (n = 0; n < 32; n++) begin
      model_regs[n] = '0;
    end
    for (n = 0; n < 10; n++) begin
      @(posedge clk);
    end
    #1 arst_n = 1'b1;

    // Every register reads zero after reset
    for (n = 0; n < 32; n++) begin
      @(posedge clk);
      #1;
      r5     = n[4:0];
      e      = '0;
      e.kind = K_RES;
      e.rd   = r5;
      drive_instr({12'h000, r5, 3'b000, r5, 7'b0010011}, 32'h100 + 4 * n, e);
    end

    next_pc = 32'h0000_1000;
    n = 0;
    while (n < NUM_RANDOM) begin
      @(posedge clk);
      #1;
      if ($urandom_range(0, 3) != 0) begin
        pick_instr(next_pc, word, e);
        drive_instr(word, next_pc, e);
        next_pc = next_pc + ((word[1:0] == 2'b11) ? 32'd4 : 32'd2);
        n++;
      end else begin
        instr_valid = 1'b0;
        instr       = $urandom;
        pc          = $urandom;
      end
    end
    @(posedge clk);
    #1 instr_valid = 1'b0;

    n = 0;
    while (exp_q.size() != 0 && n < END_TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    // A few idle cycles catch stray pulses
    for (n = 0; n < 4; n++) begin
      @(posedge clk);
    end
    if (exp_q.size() != 0) begin
      report_error("Timeout waiting for the output pulses of issued instructions");
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module alu
  import core_pkg::*;
(
  input  alu_op_t          op,
  input  logic [`XLEN-1:0] a,
  input  logic [`XLEN-1:0] b,
  output logic [`XLEN-1:0] y
);

  localparam int SHW = $clog2(`XLEN);

  logic [SHW-1:0] shamt;
  logic           lt_signed;
  logic           lt_unsigned;

  assign shamt       = b[SHW-1:0];
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      ALU_ADD: begin
        y = a + b;
      end
      ALU_SUB: begin
        y = a - b;
      end
      ALU_AND: begin
        y = a & b;
      end
      ALU_OR: begin
        y = a | b;
      end
      ALU_XOR: begin
        y = a ^ b;
      end
      ALU_SLL: begin
        y = a << shamt;
      end
      ALU_SRL: begin
        y = a >> shamt;
      end
      ALU_SRA: begin
        y = $signed(a) >>> shamt;
      end
      ALU_SLT: begin
        y = {{(`XLEN-1){1'b0}}, lt_signed};
      end
      ALU_SLTU: begin
        y = {{(`XLEN-1){1'b0}}, lt_unsigned};
      end
      default: begin
        y = '0;
      end
    endcase
  end

endmodule

// ==== verilog/core_config.svh ====
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

`define XLEN          32
`define REG_AW        5
`define REG_RESET_VAL 32'h0000_0000

// RV32I patterns laid out as funct7_rs2_rs1_funct3_rd_opcode
`define LUI   32'b???????_?????_?????_???_?????_0110111
`define AUIPC 32'b???????_?????_?????_???_?????_0010111

`define ADDI  32'b???????_?????_?????_000_?????_0010011
`define SLTI  32'b???????_?????_?????_010_?????_0010011
`define SLTIU 32'b???????_?????_?????_011_?????_0010011
`define XORI  32'b???????_?????_?????_100_?????_0010011
`define ORI   32'b???????_?????_?????_110_?????_0010011
`define ANDI  32'b???????_?????_?????_111_?????_0010011
`define SLLI  32'b0000000_?????_?????_001_?????_0010011
`define SRLI  32'b0000000_?????_?????_101_?????_0010011
`define SRAI  32'b0100000_?????_?????_101_?????_0010011

`define ADD   32'b0000000_?????_?????_000_?????_0110011
`define SUB   32'b0100000_?????_?????_000_?????_0110011
`define SLL   32'b0000000_?????_?????_001_?????_0110011
`define SLT   32'b0000000_?????_?????_010_?????_0110011
`define SLTU  32'b0000000_?????_?????_011_?????_0110011
`define XOR   32'b0000000_?????_?????_100_?????_0110011
`define SRL   32'b0000000_?????_?????_101_?????_0110011
`define SRA   32'b0100000_?????_?????_101_?????_0110011
`define OR    32'b0000000_?????_?????_110_?????_0110011
`define AND   32'b0000000_?????_?????_111_?????_0110011

`define LB    32'b???????_?????_?????_000_?????_0000011
`define LH    32'b???????_?????_?????_001_?????_0000011
`define LW    32'b???????_?????_?????_010_?????_0000011
`define LBU   32'b???????_?????_?????_100_?????_0000011
`define LHU   32'b???????_?????_?????_101_?????_0000011
`define SB    32'b???????_?????_?????_000_?????_0100011
`define SH    32'b???????_?????_?????_001_?????_0100011
`define SW    32'b???????_?????_?????_010_?????_0100011

// Compressed forms sit in the low half, the upper half is ignored
`define C_ADDI 32'b????????_????????_000?_????_????_??01
`define C_LI   32'b????????_????????_010?_????_????_??01
`define C_LUI  32'b????????_????????_011?_????_????_??01
`define C_ANDI 32'b????????_????????_100?_10??_????_??01
`define C_SUB  32'b????????_????????_1000_11??_?00?_??01
`define C_XOR  32'b????????_????????_1000_11??_?01?_??01
`define C_OR   32'b????????_????????_1000_11??_?10?_??01
`define C_AND  32'b????????_????????_1000_11??_?11?_??01
`define C_MV   32'b????????_????????_1000_????_????_??10
`define C_ADD  32'b????????_????????_1001_????_????_??10

`endif

// ==== verilog/core_pkg.sv ====
package core_pkg;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9
  } alu_op_t;

  // Memory request type carried out on mem_op
  typedef enum logic [3:0] {
    LSU_NONE = 4'd0,
    LSU_LB   = 4'd1,
    LSU_LH   = 4'd2,
    LSU_LW   = 4'd3,
    LSU_LBU  = 4'd4,
    LSU_LHU  = 4'd5,
    LSU_SB   = 4'd6,
    LSU_SH   = 4'd7,
    LSU_SW   = 4'd8
  } lsu_op_t;

  typedef enum logic [1:0] {
    CLASS_ALU     = 2'd0,
    CLASS_LSU     = 2'd1,
    CLASS_ILLEGAL = 2'd2
  } inst_class_t;

endpackage

// ==== verilog/dec_decode.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module dec_decode
  import core_pkg::*;
(
  input  logic [`XLEN-1:0]   instr,
  output logic [`REG_AW-1:0] rs1_addr,
  output logic [`REG_AW-1:0] rs2_addr,
  output logic [`REG_AW-1:0] rd_addr,
  output logic [`XLEN-1:0]   imm,
  output logic               use_imm,
  output logic               use_pc,
  output logic               rd_en,
  output alu_op_t            alu_op,
  output lsu_op_t            lsu_op,
  output inst_class_t        inst_class
);

  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_s;
  logic [`XLEN-1:0] imm_u;
  logic [`XLEN-1:0] c_imm6;
  logic [`XLEN-1:0] c_imm_lui;

  // Compressed three-bit register fields address x8 to x15
  logic [`REG_AW-1:0] c_rs1p;
  logic [`REG_AW-1:0] c_rs2p;

  assign imm_i     = {{20{instr[31]}}, instr[31:20]};
  assign imm_s     = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_u     = {instr[31:12], 12'b0};
  assign c_imm6    = {{27{instr[12]}}, instr[6:2]};
  assign c_imm_lui = {{15{instr[12]}}, instr[6:2], 12'b0};

  assign c_rs1p = {2'b01, instr[9:7]};
  assign c_rs2p = {2'b01, instr[4:2]};

  // Maps funct3 and the alternate bit (instr[30]) to an ALU operation
  function automatic alu_op_t funct_op(input logic [2:0] funct3, input logic alt);
    alu_op_t op;
    case (funct3)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  always_comb begin
    rs1_addr   = instr[19:15];
    rs2_addr   = instr[24:20];
    rd_addr    = instr[11:7];
    imm        = '0;
    use_imm    = 1'b0;
    use_pc     = 1'b0;
    rd_en      = 1'b0;
    alu_op     = ALU_ADD;
    lsu_op     = LSU_NONE;
    inst_class = CLASS_ILLEGAL;

    casez (instr)
      `ADDI, `SLTI, `SLTIU, `XORI, `ORI, `ANDI, `SLLI, `SRLI, `SRAI: begin
        inst_class = CLASS_ALU;
        rd_en      = 1'b1;
        use_imm    = 1'b1;
        imm        = imm_i;
        // Only the shift-right form uses instr[30] as an opcode bit
        alu_op     = funct_op(instr[14:12], (instr[14:12] == 3'b101) && instr[30]);
      end
      `ADD, `SUB, `SLL, `SLT, `SLTU, `XOR, `SRL, `SRA, `OR, `AND: begin
        inst_class = CLASS_ALU;
        rd_en      = 1'b1;
        alu_op     = funct_op(instr[14:12], instr[30]);
      end
      `LUI: begin
        inst_class = CLASS_ALU;
        rd_en      = 1'b1;
        use_imm    = 1'b1;
        imm        = imm_u;
        rs1_addr   = '0;
      end
      `AUIPC: begin
        inst_class = CLASS_ALU;
        rd_en      = 1'b1;
        use_imm    = 1'b1;
        use_pc     = 1'b1;
        imm        = imm_u;
      end
      `LB:  lsu_op = LSU_LB;
      `LH:  lsu_op = LSU_LH;
      `LW:  lsu_op = LSU_LW;
      `LBU: lsu_op = LSU_LBU;
      `LHU: lsu_op = LSU_LHU;
      `SB:  lsu_op = LSU_SB;
      `SH:  lsu_op = LSU_SH;
      `SW:  lsu_op = LSU_SW;
      `C_ADDI, `C_LI: begin
        inst_class = CLASS_ALU;
        rd_en      = 1'b1;
        use_imm    = 1'b1;
        imm        = c_imm6;
        rs1_addr   = instr[14] ? '0 : instr[11:7];
        rd_addr    = instr[11:7];
      end
      `C_LUI: begin
        // rd of x2 is C.ADDI16SP, which this slice does not support
        if (instr[11:7] != 5'd2) begin
          inst_class = CLASS_ALU;
          rd_en      = 1'b1;
          use_imm    = 1'b1;
          imm        = c_imm_lui;
          rs1_addr   = '0;
          rd_addr    = instr[11:7];
        end
      end
      `C_ANDI: begin
        inst_class = CLASS_ALU;
        rd_en      = 1'b1;
        use_imm    = 1'b1;
        imm        = c_imm6;
        alu_op     = ALU_AND;
        rs1_addr   = c_rs1p;
        rd_addr    = c_rs1p;
      end
      `C_SUB, `C_XOR, `C_OR, `C_AND: begin
        inst_class = CLASS_ALU;
        rd_en      = 1'b1;
        rs1_addr   = c_rs1p;
        rs2_addr   = c_rs2p;
        rd_addr    = c_rs1p;
        case (instr[6:5])
          2'b00:   alu_op = ALU_SUB;
          2'b01:   alu_op = ALU_XOR;
          2'b10:   alu_op = ALU_OR;
          default: alu_op = ALU_AND;
        endcase
      end
      `C_MV, `C_ADD: begin
        // rs2 of x0 encodes the jump forms, left illegal
        if (instr[6:2] != 5'd0) begin
          inst_class = CLASS_ALU;
          rd_en      = 1'b1;
          rs1_addr   = instr[12] ? instr[11:7] : '0;
          rs2_addr   = instr[6:2];
          rd_addr    = instr[11:7];
        end
      end
      default: ;
    endcase

    if (lsu_op != LSU_NONE) begin
      inst_class = CLASS_LSU;
      use_imm    = 1'b1;
      imm        = instr[5] ? imm_s : imm_i;
    end
  end

  dec_alu_no_mem: assert final (!(inst_class == CLASS_ALU && lsu_op != LSU_NONE))
    else $error("ALU class decoded with a memory operation");

endmodule

// ==== verilog/exec_slice.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module exec_slice
  import core_pkg::*;
(
  input  logic               clk,
  input  logic               arst_n,
  input  logic               instr_valid,
  input  logic [`XLEN-1:0]   instr,
  input  logic [`XLEN-1:0]   pc,
  output logic               res_valid,
  output logic [`REG_AW-1:0] res_rd,
  output logic [`XLEN-1:0]   res_data,
  output logic               mem_rd_en,
  output logic               mem_wr_en,
  output lsu_op_t            mem_op,
  output logic [`XLEN-1:0]   mem_addr,
  output logic [`XLEN-1:0]   mem_wdata,
  output logic               trap,
  output logic [`XLEN-1:0]   trap_pc
);

  logic [`REG_AW-1:0] rs1_addr;
  logic [`REG_AW-1:0] rs2_addr;
  logic [`REG_AW-1:0] rd_addr;
  logic [`XLEN-1:0]   imm;
  logic               use_imm;
  logic               use_pc;
  logic               rd_en;
  alu_op_t            dec_alu_op;
  alu_op_t            alu_op;
  lsu_op_t            lsu_op;
  inst_class_t        inst_class;

  logic [`XLEN-1:0] rs1_data;
  logic [`XLEN-1:0] rs2_data;
  logic [`XLEN-1:0] op_a;
  logic [`XLEN-1:0] op_b;
  logic [`XLEN-1:0] alu_y;
  logic             rf_wr_en;
  logic             is_store;

  dec_decode i_dec_decode (
    .instr      (instr),
    .rs1_addr   (rs1_addr),
    .rs2_addr   (rs2_addr),
    .rd_addr    (rd_addr),
    .imm        (imm),
    .use_imm    (use_imm),
    .use_pc     (use_pc),
    .rd_en      (rd_en),
    .alu_op     (dec_alu_op),
    .lsu_op     (lsu_op),
    .inst_class (inst_class)
  );

  reg_file i_reg_file (
    .clk      (clk),
    .arst_n   (arst_n),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wr_en    (rf_wr_en),
    .wr_addr  (rd_addr),
    .wr_data  (alu_y)
  );

  assign op_a = use_pc ? pc : rs1_data;
  assign op_b = use_imm ? imm : rs2_data;

  // Memory address generation shares the ALU adder
  assign alu_op = (inst_class == CLASS_LSU) ? ALU_ADD : dec_alu_op;

  alu i_alu (
    .op (alu_op),
    .a  (op_a),
    .b  (op_b),
    .y  (alu_y)
  );

  // A write to x0 still pulses res_valid, the register file drops it
  assign rf_wr_en = instr_valid && (inst_class == CLASS_ALU) && rd_en;
  assign is_store = lsu_op inside {LSU_SB, LSU_SH, LSU_SW};

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      res_valid <= 1'b0;
      mem_rd_en <= 1'b0;
      mem_wr_en <= 1'b0;
      trap      <= 1'b0;
    end else begin
      res_valid <= rf_wr_en;
      mem_rd_en <= instr_valid && (inst_class == CLASS_LSU) && !is_store;
      mem_wr_en <= instr_valid && (inst_class == CLASS_LSU) && is_store;
      trap      <= instr_valid && (inst_class == CLASS_ILLEGAL);
    end
  end

  always_ff @(posedge clk) begin
    if (instr_valid) begin
      res_rd    <= rd_addr;
      res_data  <= alu_y;
      mem_op    <= lsu_op;
      mem_addr  <= alu_y;
      mem_wdata <= rs2_data;
      trap_pc   <= pc;
    end
  end

  ex_mem_excl: assert property (
    @(posedge clk) disable iff (!arst_n) !(mem_rd_en && mem_wr_en)
  ) else $error("Load and store requested in the same cycle");

  ex_trap_excl: assert property (
    @(posedge clk) disable iff (!arst_n) !(trap && res_valid)
  ) else $error("Trap raised together with a result");

endmodule

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module reg_file (
  input  logic               clk,
  input  logic               arst_n,
  input  logic [`REG_AW-1:0] rs1_addr,
  input  logic [`REG_AW-1:0] rs2_addr,
  output logic [`XLEN-1:0]   rs1_data,
  output logic [`XLEN-1:0]   rs2_data,
  input  logic               wr_en,
  input  logic [`REG_AW-1:0] wr_addr,
  input  logic [`XLEN-1:0]   wr_data
);

  localparam int NUM_REGS = 1 << `REG_AW;

  // x0 has no storage
  logic [`XLEN-1:0] regs [1:NUM_REGS-1];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= `REG_RESET_VAL;
      end
    end else if (wr_en && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // Reads see the value written on the previous edge, so no forwarding is needed
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

  rf_write_then_read: assert property (
    @(posedge clk) disable iff (!arst_n)
    (wr_en && wr_addr != '0) |=>
      (rs1_addr != $past(wr_addr) || rs1_data == $past(wr_data))
  ) else $error("Read after write did not return the written value");

endmodule
